//--- rtl/blur_pkg.sv
package blur_pkg;

  // pixel format
  localparam int PIX_W = 8;

  typedef logic [PIX_W-1:0] pixel_t;

  // sequencer phases
  typedef enum logic [2:0] {
    ST_IDLE       = 3'd0,
    ST_FETCH_ROWS = 3'd1,
    ST_FLUSH      = 3'd2,
    ST_DRAIN      = 3'd3,
    ST_NEXT_STRIP = 3'd4
  } blur_state_e;

  // 1 2 1 / 2 4 2 / 1 2 1 weights sum to 16
  localparam int KERNEL_SHIFT = 4;

  // window strobe to visible blur SRAM write
  localparam int PIPE_DEPTH = 2;

endpackage

//--- rtl/blur_sequencer.sv
`timescale 1ns/1ns

module blur_sequencer #(
  parameter int IMG_ROWS = 16,
  parameter int IMG_COLS = 32,
  parameter int STRIP_W  = 8
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                start,
  output logic                                done,
  output logic [$clog2(IMG_ROWS)-1:0]         img_addr,
  output logic [$clog2(IMG_COLS/STRIP_W)-1:0] strip_col,
  output logic                                row_valid,
  output logic                                fill_zero,
  output logic                                strip_clear,
  output logic                                window_valid,
  output logic [$clog2(IMG_ROWS)-1:0]         out_row
);

  import blur_pkg::*;

  localparam int NUM_STRIPS  = IMG_COLS / STRIP_W;
  localparam int ROW_W       = $clog2(IMG_ROWS);
  localparam int STRIP_IDX_W = $clog2(NUM_STRIPS);
  localparam int DRAIN_W     = $clog2(PIPE_DEPTH) + 1;

  localparam logic [ROW_W-1:0]       LAST_ROW   = ROW_W'(IMG_ROWS - 1);
  localparam logic [STRIP_IDX_W-1:0] LAST_STRIP = STRIP_IDX_W'(NUM_STRIPS - 1);

  blur_state_e        state;
  logic [DRAIN_W-1:0] drain_cnt;
  logic               last_strip;
  logic               launch;

  assign last_strip = (strip_col == LAST_STRIP);

  // a new strip begins on an accepted start or after a finished strip
  assign launch = (state == ST_IDLE && start) ||
                  (state == ST_NEXT_STRIP && !last_strip);

  // strip and row walk
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= ST_IDLE;
      img_addr  <= '0;
      strip_col <= '0;
      drain_cnt <= '0;
      done      <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (start) begin
            state     <= ST_FETCH_ROWS;
            img_addr  <= '0;
            strip_col <= '0;
            done      <= 1'b0;
          end
        end
        ST_FETCH_ROWS: begin
          // one image row address per cycle
          if (img_addr == LAST_ROW) begin
            state <= ST_FLUSH;
          end else begin
            img_addr <= img_addr + 1'b1;
          end
        end
        ST_FLUSH: begin
          state     <= ST_DRAIN;
          drain_cnt <= '0;
        end
        ST_DRAIN: begin
          // let the kernel and merge stages empty
          if (drain_cnt == DRAIN_W'(PIPE_DEPTH - 1)) begin
            state <= ST_NEXT_STRIP;
          end else begin
            drain_cnt <= drain_cnt + 1'b1;
          end
        end
        ST_NEXT_STRIP: begin
          if (last_strip) begin
            state <= ST_IDLE;
            done  <= 1'b1;
          end else begin
            state     <= ST_FETCH_ROWS;
            strip_col <= strip_col + 1'b1;
            img_addr  <= '0;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // strobes trail the state by one cycle, matching the SRAM read latency
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      row_valid    <= 1'b0;
      fill_zero    <= 1'b0;
      strip_clear  <= 1'b0;
      window_valid <= 1'b0;
    end else begin
      row_valid    <= (state == ST_FETCH_ROWS);
      fill_zero    <= (state == ST_FLUSH);
      strip_clear  <= launch;
      // row r is complete once row r+1 (or the zero row) arrives
      window_valid <= (state == ST_FETCH_ROWS && img_addr != '0) ||
                      (state == ST_FLUSH);
    end
  end

  // output row is one behind the fetched row, the last one comes with the flush
  always_ff @(posedge clk) begin
    if (state == ST_FLUSH) begin
      out_row <= img_addr;
    end else begin
      out_row <= img_addr - 1'b1;
    end
  end

endmodule

//--- rtl/blur_line_buffer.sv
`timescale 1ns/1ns

module blur_line_buffer #(
  parameter int IMG_COLS = 32,
  parameter int STRIP_W  = 8
) (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic [IMG_COLS*blur_pkg::PIX_W-1:0]     img_dout,
  input  logic [$clog2(IMG_COLS/STRIP_W)-1:0]     strip_col,
  input  logic                                    row_valid,
  input  logic                                    fill_zero,
  input  logic                                    strip_clear,
  output logic [(STRIP_W+2)*blur_pkg::PIX_W-1:0]  win_top,
  output logic [(STRIP_W+2)*blur_pkg::PIX_W-1:0]  win_mid,
  output logic [(STRIP_W+2)*blur_pkg::PIX_W-1:0]  win_bot
);

  import blur_pkg::*;

  // strip plus one halo pixel on each side
  localparam int WIN_PIX = STRIP_W + 2;

  pixel_t [IMG_COLS-1:0] img_pix;
  pixel_t [WIN_PIX-1:0]  new_row;
  pixel_t [WIN_PIX-1:0]  top_q;
  pixel_t [WIN_PIX-1:0]  mid_q;

  assign img_pix = img_dout;

  // cut the strip out of the incoming row, halo outside the image reads as zero
  always_comb begin
    int col;
    for (int i = 0; i < WIN_PIX; i++) begin
      col = int'(strip_col) * STRIP_W + i - 1;
      if (fill_zero || col < 0 || col >= IMG_COLS) begin
        new_row[i] = '0;
      end else begin
        new_row[i] = img_pix[col];
      end
    end
  end

  // two stored rows, the third is the row arriving this cycle
  always_ff @(posedge clk) begin
    if (!rst_n || strip_clear) begin
      top_q <= '0;
      mid_q <= '0;
    end else if (row_valid || fill_zero) begin
      top_q <= mid_q;
      mid_q <= new_row;
    end
  end

  assign win_top = top_q;
  assign win_mid = mid_q;
  assign win_bot = new_row;

endmodule

//--- rtl/blur_kernel_3x3.sv
`timescale 1ns/1ns

module blur_kernel_3x3 #(
  parameter int STRIP_W = 8
) (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic [(STRIP_W+2)*blur_pkg::PIX_W-1:0]  win_top,
  input  logic [(STRIP_W+2)*blur_pkg::PIX_W-1:0]  win_mid,
  input  logic [(STRIP_W+2)*blur_pkg::PIX_W-1:0]  win_bot,
  input  logic                                    window_valid,
  output logic [STRIP_W*blur_pkg::PIX_W-1:0]      blur_row,
  output logic                                    result_valid
);

  import blur_pkg::*;

  localparam int WIN_PIX = STRIP_W + 2;
  localparam int SUM_W   = PIX_W + KERNEL_SHIFT;

  pixel_t [WIN_PIX-1:0] top;
  pixel_t [WIN_PIX-1:0] mid;
  pixel_t [WIN_PIX-1:0] bot;
  pixel_t [STRIP_W-1:0] blur_next;

  // horizontal 1 2 1 pass
  function automatic logic [PIX_W+1:0] tap121(input pixel_t a, input pixel_t b,
                                             input pixel_t c);
    tap121 = {2'b00, a} + {1'b0, b, 1'b0} + {2'b00, c};
  endfunction

  assign top = win_top;
  assign mid = win_mid;
  assign bot = win_bot;

  // output pixel j is centred on window pixel j+1
  always_comb begin
    logic [SUM_W-1:0] sum;
    for (int j = 0; j < STRIP_W; j++) begin
      sum = SUM_W'(tap121(top[j], top[j+1], top[j+2])) +
            (SUM_W'(tap121(mid[j], mid[j+1], mid[j+2])) << 1) +
            SUM_W'(tap121(bot[j], bot[j+1], bot[j+2]));
      blur_next[j] = pixel_t'(sum >> KERNEL_SHIFT);
    end
  end

  always_ff @(posedge clk) begin
    if (window_valid) begin
      blur_row <= blur_next;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= window_valid;
    end
  end

endmodule

//--- rtl/blur_row_merge.sv
`timescale 1ns/1ns

module blur_row_merge #(
  parameter int IMG_ROWS = 16,
  parameter int IMG_COLS = 32,
  parameter int STRIP_W  = 8
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                window_valid,
  input  logic [$clog2(IMG_ROWS)-1:0]         out_row,
  input  logic [$clog2(IMG_COLS/STRIP_W)-1:0] strip_col,
  input  logic [STRIP_W*blur_pkg::PIX_W-1:0]  blur_row,
  input  logic                                result_valid,
  input  logic [IMG_COLS*blur_pkg::PIX_W-1:0] blur_dout,
  output logic [$clog2(IMG_ROWS)-1:0]         blur_addr_r,
  output logic                                blur_we,
  output logic [$clog2(IMG_ROWS)-1:0]         blur_addr_w,
  output logic [IMG_COLS*blur_pkg::PIX_W-1:0] blur_din
);

  import blur_pkg::*;

  localparam int NUM_STRIPS  = IMG_COLS / STRIP_W;
  localparam int ROW_W       = $clog2(IMG_ROWS);
  localparam int STRIP_IDX_W = $clog2(NUM_STRIPS);

  pixel_t [IMG_COLS-1:0]  old_word;
  pixel_t [STRIP_W-1:0]   strip_pix;
  pixel_t [IMG_COLS-1:0]  merged;
  logic [ROW_W-1:0]       row_q;
  logic [STRIP_IDX_W-1:0] strip_q;

  // read the row word while the kernel computes
  assign blur_addr_r = out_row;

  assign old_word  = blur_dout;
  assign strip_pix = blur_row;

  // row and strip of the result arriving next cycle
  always_ff @(posedge clk) begin
    if (window_valid) begin
      row_q   <= out_row;
      strip_q <= strip_col;
    end
  end

  // earlier strips kept, current strip replaced, later strips zero
  always_comb begin
    for (int s = 0; s < NUM_STRIPS; s++) begin
      if (s < int'(strip_q)) begin
        merged[s*STRIP_W +: STRIP_W] = old_word[s*STRIP_W +: STRIP_W];
      end else if (s == int'(strip_q)) begin
        merged[s*STRIP_W +: STRIP_W] = strip_pix;
      end else begin
        merged[s*STRIP_W +: STRIP_W] = '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      blur_we <= 1'b0;
    end else begin
      blur_we <= result_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (result_valid) begin
      blur_addr_w <= row_q;
      blur_din    <= merged;
    end
  end

endmodule

//--- rtl/gaussian_blur.sv
`timescale 1ns/1ns

module gaussian_blur #(
  parameter int IMG_ROWS = 16,
  parameter int IMG_COLS = 32,
  parameter int STRIP_W  = 8
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                start,
  output logic                                done,
  output logic [$clog2(IMG_ROWS)-1:0]         img_addr,
  input  logic [IMG_COLS*blur_pkg::PIX_W-1:0] img_dout,
  output logic [$clog2(IMG_ROWS)-1:0]         blur_addr_r,
  input  logic [IMG_COLS*blur_pkg::PIX_W-1:0] blur_dout,
  output logic                                blur_we,
  output logic [$clog2(IMG_ROWS)-1:0]         blur_addr_w,
  output logic [IMG_COLS*blur_pkg::PIX_W-1:0] blur_din
);

  import blur_pkg::*;

  localparam int ROW_W       = $clog2(IMG_ROWS);
  localparam int STRIP_IDX_W = $clog2(IMG_COLS / STRIP_W);
  localparam int WIN_W       = (STRIP_W + 2) * PIX_W;

  logic [STRIP_IDX_W-1:0]   strip_col;
  logic                     row_valid;
  logic                     fill_zero;
  logic                     strip_clear;
  logic                     window_valid;
  logic [ROW_W-1:0]         out_row;
  logic [WIN_W-1:0]         win_top;
  logic [WIN_W-1:0]         win_mid;
  logic [WIN_W-1:0]         win_bot;
  logic [STRIP_W*PIX_W-1:0] blur_row;
  logic                     result_valid;

  blur_sequencer #(
    .IMG_ROWS (IMG_ROWS),
    .IMG_COLS (IMG_COLS),
    .STRIP_W  (STRIP_W)
  ) u_seq (
    .clk          (clk),
    .rst_n        (rst_n),
    .start        (start),
    .done         (done),
    .img_addr     (img_addr),
    .strip_col    (strip_col),
    .row_valid    (row_valid),
    .fill_zero    (fill_zero),
    .strip_clear  (strip_clear),
    .window_valid (window_valid),
    .out_row      (out_row)
  );

  blur_line_buffer #(
    .IMG_COLS (IMG_COLS),
    .STRIP_W  (STRIP_W)
  ) u_lb (
    .clk         (clk),
    .rst_n       (rst_n),
    .img_dout    (img_dout),
    .strip_col   (strip_col),
    .row_valid   (row_valid),
    .fill_zero   (fill_zero),
    .strip_clear (strip_clear),
    .win_top     (win_top),
    .win_mid     (win_mid),
    .win_bot     (win_bot)
  );

  blur_kernel_3x3 #(
    .STRIP_W (STRIP_W)
  ) u_kernel (
    .clk          (clk),
    .rst_n        (rst_n),
    .win_top      (win_top),
    .win_mid      (win_mid),
    .win_bot      (win_bot),
    .window_valid (window_valid),
    .blur_row     (blur_row),
    .result_valid (result_valid)
  );

  blur_row_merge #(
    .IMG_ROWS (IMG_ROWS),
    .IMG_COLS (IMG_COLS),
    .STRIP_W  (STRIP_W)
  ) u_merge (
    .clk          (clk),
    .rst_n        (rst_n),
    .window_valid (window_valid),
    .out_row      (out_row),
    .strip_col    (strip_col),
    .blur_row     (blur_row),
    .result_valid (result_valid),
    .blur_dout    (blur_dout),
    .blur_addr_r  (blur_addr_r),
    .blur_we      (blur_we),
    .blur_addr_w  (blur_addr_w),
    .blur_din     (blur_din)
  );

endmodule

//--- test/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int HALF_PERIOD  = 5,
  parameter int RESET_CYCLES = 3
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // reset held low for a few rising edges
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

//--- test/gaussian_blur_assert.sv
`timescale 1ns/1ns

module gaussian_blur_assert #(
  parameter int IMG_ROWS = 16
) (
  input logic                        clk,
  input logic                        rst_n,
  input logic                        done,
  input logic                        blur_we,
  input logic                        window_valid,
  input logic [$clog2(IMG_ROWS)-1:0] blur_addr_r,
  input logic [$clog2(IMG_ROWS)-1:0] blur_addr_w
);

  import blur_pkg::*;

  // the write goes back to the row word that was read for the merge
  a_write_addr: assert property (@(posedge clk) disable iff (!rst_n)
    blur_we |-> (int'(blur_addr_w) < IMG_ROWS) &&
                (blur_addr_w == $past(blur_addr_r, PIPE_DEPTH)))
    else $error("blur write address outside the image or not the row that was read");

  a_done_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    !(done && blur_we))
    else $error("blur write while done is high");

  // every complete window ends in exactly one write
  a_window_write: assert property (@(posedge clk) disable iff (!rst_n)
    window_valid |-> ##PIPE_DEPTH blur_we)
    else $error("window strobe not followed by a blur write");

endmodule

//--- test/blur_checker.sv
`timescale 1ns/1ns

module blur_checker #(
  parameter int IMG_ROWS = 16,
  parameter int IMG_COLS = 32,
  parameter int STRIP_W  = 8
) (
  input logic                                clk,
  input logic                                rst_n,
  input logic                                start,
  input logic                                done,
  input logic [$clog2(IMG_ROWS)-1:0]         img_addr,
  input logic                                blur_we,
  input logic [$clog2(IMG_ROWS)-1:0]         blur_addr_w,
  input logic [IMG_COLS*blur_pkg::PIX_W-1:0] blur_din
);

  import blur_pkg::*;

  localparam int NUM_STRIPS  = IMG_COLS / STRIP_W;
  localparam int WORD_W      = IMG_COLS * PIX_W;
  localparam int SLOT_W      = STRIP_W * PIX_W;
  localparam int PASS_WRITES = IMG_ROWS * NUM_STRIPS;
  // fetch rows, flush, drain, next strip
  localparam int STRIP_CYCLES = IMG_ROWS + 1 + PIPE_DEPTH + 1;

  logic [WORD_W-1:0] img_model [IMG_ROWS];
  logic [WORD_W-1:0] mem_model [IMG_ROWS];
  logic [WORD_W-1:0] golden [IMG_ROWS];
  int                value_errors;
  int                order_errors;
  int                protocol_errors;
  int                checked;
  int                writes;
  int                fetch_pos;
  bit                idle;
  bit                exp_done;
  bit                accept;

  initial begin
    value_errors    = 0;
    order_errors    = 0;
    protocol_errors = 0;
    checked         = 0;
    writes          = 0;
    fetch_pos       = 0;
    idle            = 1'b1;
    exp_done        = 1'b0;
  end

  task automatic load_image_row(input int r, input logic [WORD_W-1:0] word);
    img_model[r] = word;
  endtask

  task automatic load_memory_row(input int r, input logic [WORD_W-1:0] word);
    mem_model[r] = word;
  endtask

  // zero outside the image
  function automatic int pixel_at(input int r, input int c);
    if (r < 0 || r >= IMG_ROWS || c < 0 || c >= IMG_COLS) begin
      return 0;
    end
    return int'(img_model[r][c*PIX_W +: PIX_W]);
  endfunction

  // full-image 3x3 binomial blur, truncated
  task automatic build_golden();
    int sum;
    int wr;
    int wc;
    for (int r = 0; r < IMG_ROWS; r++) begin
      for (int c = 0; c < IMG_COLS; c++) begin
        sum = 0;
        for (int dr = -1; dr <= 1; dr++) begin
          for (int dc = -1; dc <= 1; dc++) begin
            wr = (dr == 0) ? 2 : 1;
            wc = (dc == 0) ? 2 : 1;
            sum += wr * wc * pixel_at(r + dr, c + dc);
          end
        end
        golden[r][c*PIX_W +: PIX_W] = PIX_W'(sum >> KERNEL_SHIFT);
      end
    end
  endtask

  // lower slots kept, own slot blurred, upper slots zero
  function automatic logic [WORD_W-1:0] expected_word(input int row, input int strip);
    logic [WORD_W-1:0] w;
    w = '0;
    for (int s = 0; s < NUM_STRIPS; s++) begin
      if (s < strip) begin
        w[s*SLOT_W +: SLOT_W] = mem_model[row][s*SLOT_W +: SLOT_W];
      end else if (s == strip) begin
        w[s*SLOT_W +: SLOT_W] = golden[row][s*SLOT_W +: SLOT_W];
      end
    end
    return w;
  endfunction

  // one image row address per cycle at the start of every strip period
  task automatic check_fetch_addr();
    int pos;
    pos = fetch_pos % STRIP_CYCLES;
    if (pos < IMG_ROWS && int'(img_addr) != pos) begin
      order_errors++;
      $display("Fail at %0t ns: img_addr expected %0d got %0d", $time, pos, img_addr);
    end
    fetch_pos++;
  endtask

  task automatic check_write();
    int                strip;
    int                row;
    logic [WORD_W-1:0] exp_w;
    if (idle) begin
      order_errors++;
      $display("Error: blur SRAM written at %0t ns while no pass was running", $time);
    end else begin
      // rows top to bottom within a strip, strips left to right
      strip = writes / IMG_ROWS;
      row   = writes % IMG_ROWS;
      exp_w = expected_word(row, strip);
      if (int'(blur_addr_w) != row) begin
        order_errors++;
        $display("Fail at %0t ns: blur_addr_w expected %0d got %0d", $time, row, blur_addr_w);
      end
      if (blur_din !== exp_w) begin
        value_errors++;
        $display("Fail at %0t ns: blur_din expected %h got %h", $time, exp_w, blur_din);
      end
      mem_model[row] = exp_w;
      writes++;
      checked++;
      if (writes == PASS_WRITES) begin
        idle     = 1'b1;
        exp_done = 1'b1;
      end
    end
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      writes   = 0;
      idle     = 1'b1;
      exp_done = 1'b0;
    end else begin
      if (done !== exp_done) begin
        protocol_errors++;
        $display("Fail at %0t ns: done expected %b got %b", $time, exp_done, done);
      end
      // a start only counts when no pass is running
      accept = start && idle;
      if (!idle) begin
        check_fetch_addr();
      end
      if (blur_we) begin
        check_write();
      end
      if (accept) begin
        idle      = 1'b0;
        writes    = 0;
        fetch_pos = 0;
        exp_done  = 1'b0;
      end
    end
  end

  task automatic print_counts(input int tb_errs, output int total);
    total = value_errors + order_errors + protocol_errors + tb_errs;
    $display("errors: %0d value, %0d order, %0d protocol, %0d testbench (%0d writes checked)",
             value_errors, order_errors, protocol_errors, tb_errs, checked);
  endtask

endmodule

//--- test/tb_gaussian_blur.sv
`timescale 1ns/1ns

module tb_gaussian_blur;

  import blur_pkg::*;

  localparam int IMG_ROWS   = 16;
  localparam int IMG_COLS   = 32;
  localparam int STRIP_W    = 8;
  localparam int ROW_W      = $clog2(IMG_ROWS);
  localparam int WORD_W     = IMG_COLS * PIX_W;
  // about twice the length of one pass
  localparam int DONE_LIMIT = 2 * (IMG_COLS / STRIP_W) * (IMG_ROWS + PIPE_DEPTH + 2);

  logic              clk;
  logic              rst_n;
  logic              start;
  logic              done;
  logic [ROW_W-1:0]  img_addr;
  logic [WORD_W-1:0] img_dout;
  logic [ROW_W-1:0]  blur_addr_r;
  logic [WORD_W-1:0] blur_dout;
  logic              blur_we;
  logic [ROW_W-1:0]  blur_addr_w;
  logic [WORD_W-1:0] blur_din;
  logic [WORD_W-1:0] img_mem [IMG_ROWS];
  logic [WORD_W-1:0] blur_mem [IMG_ROWS];
  logic [31:0]       lcg_state;
  int                tb_errors;
  bit                running;

  tb_clock_gen #(.RESET_CYCLES(3)) clk_gen0 (.clk(clk), .rst_n(rst_n));

  gaussian_blur #(
    .IMG_ROWS (IMG_ROWS),
    .IMG_COLS (IMG_COLS),
    .STRIP_W  (STRIP_W)
  ) dut0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (start),
    .done        (done),
    .img_addr    (img_addr),
    .img_dout    (img_dout),
    .blur_addr_r (blur_addr_r),
    .blur_dout   (blur_dout),
    .blur_we     (blur_we),
    .blur_addr_w (blur_addr_w),
    .blur_din    (blur_din)
  );

  blur_checker #(
    .IMG_ROWS (IMG_ROWS),
    .IMG_COLS (IMG_COLS),
    .STRIP_W  (STRIP_W)
  ) chk0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (start),
    .done        (done),
    .img_addr    (img_addr),
    .blur_we     (blur_we),
    .blur_addr_w (blur_addr_w),
    .blur_din    (blur_din)
  );

  bind gaussian_blur gaussian_blur_assert #(.IMG_ROWS(IMG_ROWS)) u_assert (
    .clk          (clk),
    .rst_n        (rst_n),
    .done         (done),
    .blur_we      (blur_we),
    .window_valid (window_valid),
    .blur_addr_r  (blur_addr_r),
    .blur_addr_w  (blur_addr_w)
  );

  // both memories answer one cycle after the address
  always @(posedge clk) begin
    img_dout <= img_mem[img_addr];
  end

  always @(posedge clk) begin
    if (blur_we) begin
      blur_mem[blur_addr_w] <= blur_din;
    end
    blur_dout <= blur_mem[blur_addr_r];
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic random_word(output logic [WORD_W-1:0] word);
    for (int c = 0; c < IMG_COLS; c++) begin
      lcg_state = lcg_next(lcg_state);
      word[c*PIX_W +: PIX_W] = lcg_state[23:16];
    end
  endtask

  // new image, mirrored into the checker
  task automatic fill_image();
    logic [WORD_W-1:0] word;
    for (int r = 0; r < IMG_ROWS; r++) begin
      random_word(word);
      img_mem[r] = word;
      chk0.load_image_row(r, word);
    end
    chk0.build_golden();
  endtask

  task automatic fill_blur_memory();
    logic [WORD_W-1:0] word;
    for (int r = 0; r < IMG_ROWS; r++) begin
      random_word(word);
      blur_mem[r] = word;
      chk0.load_memory_row(r, word);
    end
  endtask

  task automatic wait_for_reset(output bit ok);
    int n;
    n = 0;
    while (rst_n !== 1'b1 && n < 20) begin
      @(posedge clk);
      n++;
    end
    ok = (rst_n === 1'b1);
    if (!ok) begin
      tb_errors++;
      $display("Error: reset still active after %0d cycles", n);
    end
  endtask

  // full pass, plus a stray start while busy that must be ignored
  task automatic run_pass(output bit ok);
    int n;
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    repeat (12) @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    n = 0;
    while (done !== 1'b1 && n < DONE_LIMIT) begin
      @(posedge clk);
      n++;
    end
    ok = (done === 1'b1);
    if (!ok) begin
      tb_errors++;
      $display("Error: done did not rise within %0d cycles", DONE_LIMIT);
    end
    // done has to hold while idle
    repeat (4) @(posedge clk);
  endtask

  task automatic finish_run();
    int total;
    chk0.print_counts(tb_errors, total);
    if (total == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  endtask

  initial begin
    start     = 1'b0;
    img_dout  = '0;
    blur_dout = '0;
    tb_errors = 0;
    lcg_state = 32'd42;
    fill_image();
    fill_blur_memory();
    wait_for_reset(running);
    if (running) begin
      // no writes expected before the first start
      repeat (5) @(posedge clk);
      run_pass(running);
    end
    if (running) begin
      fill_image();
      run_pass(running);
    end
    finish_run();
  end

endmodule

//--- gaussian_blur.f
rtl/blur_pkg.sv
rtl/blur_sequencer.sv
rtl/blur_line_buffer.sv
rtl/blur_kernel_3x3.sv
rtl/blur_row_merge.sv
rtl/gaussian_blur.sv
test/tb_clock_gen.sv
test/gaussian_blur_assert.sv
test/blur_checker.sv
test/tb_gaussian_blur.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the gaussian blur testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f gaussian_blur.f \
    --top-module tb_gaussian_blur -o sim_gaussian_blur; then
  echo "build failed"
  exit 1
fi

output=$(./obj_dir/sim_gaussian_blur 2>&1)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "TESTBENCH PASSED"; then
  exit 0
fi
exit 1
